/* Bender.yml */
package:
  name: decode_execute

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/control_unit.sv
      - verilog/register_file.sv
      - verilog/instruction_decode.sv
      - verilog/id_ex.sv
      - verilog/execute.sv
      - verilog/decode_execute_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_decode_execute.sv

/* dv/tb_decode_execute.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module tb_decode_execute;

    localparam int RESET_CYCLES = 8;
    localparam int N_STEPS      = 67;  // write-backs plus stepped instructions.
    localparam int WATCHDOG_NS  = (N_STEPS + RESET_CYCLES) * 10 * 4;

    // expected execute outputs of one stepped instruction.
    typedef struct packed {
        mips_pkg::word_t      alu_result;
        mips_pkg::word_t      store_data;
        mips_pkg::reg_addr_t  write_reg;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        mips_pkg::word_size_t word_size;
        logic                 branch_taken;
        mips_pkg::word_t      branch_target;
        logic                 jump;
        mips_pkg::word_t      jump_target;
    } expect_t;

    logic                 i_clk, i_reset, i_step, i_wb_write;
    mips_pkg::word_t      i_instruction, i_pc4, i_wb_data;
    mips_pkg::reg_addr_t  i_wb_addr, o_write_reg;
    mips_pkg::word_t      o_alu_result, o_store_data, o_branch_target, o_jump_target;
    logic                 o_reg_write, o_mem_read, o_mem_write, o_branch_taken, o_jump;
    mips_pkg::word_size_t o_word_size;

    mips_pkg::word_t   model_regs [32];
    expect_t           exp_out;
    logic              check_en;
    logic [4:0]        act_flags;
    logic [4:0]        exp_flags;
    string             test_name;
    integer            seed;
    int                n_checks;
    int                n_errors;
    mips_pkg::funct_t  r_functs [10] = '{`MIPS_FC_SRA, `MIPS_FC_SRL, `MIPS_FC_SLL, `MIPS_FC_ADDU,
        `MIPS_FC_SUBU, `MIPS_FC_AND, `MIPS_FC_OR, `MIPS_FC_XOR, `MIPS_FC_NOR, `MIPS_FC_SLT};
    mips_pkg::opcode_t i_ops [6] = '{`MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_ANDI, `MIPS_OP_ORI,
        `MIPS_OP_XORI, `MIPS_OP_LUI};
    mips_pkg::opcode_t mem_ops [8] = '{`MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU,
        `MIPS_OP_LHU, `MIPS_OP_SB, `MIPS_OP_SH, `MIPS_OP_SW};

    decode_execute_top dut (.*);

    always #5 i_clk = ~i_clk;

    function automatic mips_pkg::word_t encode_r(input mips_pkg::funct_t fc, input int rs,
                                                 input int rt, input int rd, input int sh);
        return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fc};
    endfunction

    function automatic mips_pkg::word_t encode_i(input mips_pkg::opcode_t op, input int rs,
                                                 input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic expect_t predict(input mips_pkg::word_t ins, input mips_pkg::word_t pc);
        expect_t           e;
        mips_pkg::opcode_t op;
        mips_pkg::word_t   a;
        mips_pkg::word_t   b;
        mips_pkg::word_t   ext;
        op  = ins[31:26];
        a   = model_regs[ins[25:21]];
        b   = model_regs[ins[20:16]];
        ext = {{16{ins[15]}}, ins[15:0]};
        if (op == `MIPS_OP_ANDI || op == `MIPS_OP_ORI || op == `MIPS_OP_XORI)
            ext = {16'b0, ins[15:0]};  // logical immediates.
        e               = '0;
        e.store_data    = b;
        e.write_reg     = ins[20:16];
        e.reg_write     = 1'b1;
        e.branch_target = pc + (ext << 2);
        e.jump_target   = {pc[31:28], ins[25:0], 2'b00};
        case (op)
            `MIPS_OP_RTYPE: begin
                e.write_reg = ins[15:11];
                case (ins[5:0])
                    `MIPS_FC_ADDU: e.alu_result = a + b;
                    `MIPS_FC_SUBU: e.alu_result = a - b;
                    `MIPS_FC_AND:  e.alu_result = a & b;
                    `MIPS_FC_OR:   e.alu_result = a | b;
                    `MIPS_FC_XOR:  e.alu_result = a ^ b;
                    `MIPS_FC_NOR:  e.alu_result = ~(a | b);
                    `MIPS_FC_SLT:  e.alu_result = 32'($signed(a) < $signed(b));
                    `MIPS_FC_SLL:  e.alu_result = b << ins[10:6];
                    `MIPS_FC_SRL:  e.alu_result = b >> ins[10:6];
                    `MIPS_FC_SRA:  e.alu_result = $signed(b) >>> ins[10:6];
                    default: begin  // jr.
                        e.reg_write   = 1'b0;
                        e.jump        = 1'b1;
                        e.jump_target = a;
                    end
                endcase
            end
            `MIPS_OP_ADDIU: e.alu_result = a + ext;
            `MIPS_OP_SLTI:  e.alu_result = 32'($signed(a) < $signed(ext));
            `MIPS_OP_ANDI:  e.alu_result = a & ext;
            `MIPS_OP_ORI:   e.alu_result = a | ext;
            `MIPS_OP_XORI:  e.alu_result = a ^ ext;
            `MIPS_OP_LUI:   e.alu_result = {ins[15:0], 16'b0};
            `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU, `MIPS_OP_LHU: begin
                e.alu_result = a + ext;  // base plus offset.
                e.mem_read   = 1'b1;
            end
            `MIPS_OP_SB, `MIPS_OP_SH, `MIPS_OP_SW: begin
                e.alu_result = a + ext;
                e.mem_write  = 1'b1;
                e.reg_write  = 1'b0;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
                e.reg_write    = 1'b0;
                e.branch_taken = (op == `MIPS_OP_BNE) ? (a != b) : (a == b);
            end
            `MIPS_OP_J: begin
                e.reg_write = 1'b0;
                e.jump      = 1'b1;
            end
            default: begin  // jal.
                e.jump       = 1'b1;
                e.alu_result = pc;
                e.write_reg  = 5'd31;
            end
        endcase
        case (op)
            `MIPS_OP_LB, `MIPS_OP_SB: e.word_size = `MIPS_SIZE_BYTE;
            `MIPS_OP_LH, `MIPS_OP_SH: e.word_size = `MIPS_SIZE_HALF;
            `MIPS_OP_LW, `MIPS_OP_SW: e.word_size = `MIPS_SIZE_WORD;
            `MIPS_OP_LBU:             e.word_size = `MIPS_SIZE_BYTE | `MIPS_SIZE_UNSIGNED;
            `MIPS_OP_LHU:             e.word_size = `MIPS_SIZE_HALF | `MIPS_SIZE_UNSIGNED;
        endcase
        return e;
    endfunction

    task automatic report_mismatch(input string field, input mips_pkg::word_t expected,
                                   input mips_pkg::word_t actual);
        n_errors++;
        $display("Error: %s %s expected %h actual %h", test_name, field, expected, actual);
    endtask

    // steps one instruction, then holds it for some cycles while the checks run.
    task automatic run_instr(input string name, input mips_pkg::word_t ins, input int hold);
        mips_pkg::word_t pc;
        pc            = $random(seed) & 32'hffff_fffc;
        test_name     = name;
        i_instruction = ins;
        i_pc4         = pc;
        i_step        = 1'b1;
        exp_out       = predict(ins, pc);
        @(negedge i_clk);
        i_step   = 1'b0;
        check_en = 1'b1;
        repeat (hold) begin
            i_instruction = $random(seed);  // must not reach id/ex.
            n_checks++;
            @(negedge i_clk);
        end
        check_en = 1'b0;
    endtask

    task automatic load_reg(input int addr, input mips_pkg::word_t data);
        i_wb_write = 1'b1;
        i_wb_addr  = 5'(addr);
        i_wb_data  = data;
        @(negedge i_clk);
        i_wb_write = 1'b0;
        if (addr != 0)
            model_regs[addr] = data;
    endtask

    // ------------------------------------------------------------------------
    assign act_flags = {o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch_taken};
    assign exp_flags = {exp_out.reg_write, exp_out.mem_read, exp_out.mem_write, exp_out.jump,
                        exp_out.branch_taken};

    chk_flags: assert property (@(posedge i_clk) check_en |-> act_flags == exp_flags)
        else report_mismatch("control flags", exp_flags, $sampled(act_flags));
    chk_alu: assert property (@(posedge i_clk) check_en && (exp_flags[4:2] != '0) |->
            o_alu_result == exp_out.alu_result)
        else report_mismatch("alu_result", exp_out.alu_result, $sampled(o_alu_result));
    chk_write_reg: assert property (@(posedge i_clk) check_en && exp_out.reg_write |->
            o_write_reg == exp_out.write_reg)
        else report_mismatch("write_reg", exp_out.write_reg, $sampled(o_write_reg));
    chk_word_size: assert property (@(posedge i_clk) check_en && (exp_flags[3:2] != '0) |->
            o_word_size == exp_out.word_size)
        else report_mismatch("word_size", exp_out.word_size, $sampled(o_word_size));
    chk_store: assert property (@(posedge i_clk) check_en |-> o_store_data == exp_out.store_data)
        else report_mismatch("store_data", exp_out.store_data, $sampled(o_store_data));
    chk_branch_target: assert property (@(posedge i_clk) check_en |->
            o_branch_target == exp_out.branch_target)
        else report_mismatch("branch_target", exp_out.branch_target, $sampled(o_branch_target));
    chk_jump_target: assert property (@(posedge i_clk) check_en |->
            o_jump_target == exp_out.jump_target)
        else report_mismatch("jump_target", exp_out.jump_target, $sampled(o_jump_target));

    initial begin
        seed          = 32'h5e66;
        n_checks      = 0;
        n_errors      = 0;
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_step        = 1'b0;
        i_instruction = '0;
        i_pc4         = '0;
        i_wb_write    = 1'b0;
        i_wb_addr     = '0;
        i_wb_data     = '0;
        check_en      = 1'b0;
        exp_out       = '0;  // a zero payload decodes as sll r0.
        test_name     = "reset";
        foreach (model_regs[r])
            model_regs[r] = '0;
        @(negedge i_clk);
        check_en = 1'b1;
        repeat (RESET_CYCLES - 1) @(negedge i_clk);
        i_reset = 1'b0;
        repeat (2) @(negedge i_clk);
        check_en = 1'b0;

        for (int r = 1; r < 32; r++)
            load_reg(r, $random(seed));
        load_reg(12, 32'h8765_4321);  // a negative value for sra.
        load_reg(0, 32'hdead_beef);

        foreach (r_functs[i])
            run_instr("r_type", encode_r(r_functs[i], i + 1, i + 12, i + 20, 3 * i + 1), 1);
        run_instr("r0_reads_zero", encode_r(`MIPS_FC_ADDU, 0, 0, 5, 0), 1);
        foreach (i_ops[i])
            run_instr("i_type", encode_i(i_ops[i], i + 2, i + 14, 16'h8000 | 16'(i * 'h1357)), 1);
        run_instr("addiu_positive", encode_i(`MIPS_OP_ADDIU, 3, 9, 16'h0123), 1);
        foreach (mem_ops[i])
            run_instr("load_store", encode_i(mem_ops[i], i + 5, i + 17,
                      (i % 2) ? 16'hfff0 : 16'h0044), 1);
        run_instr("beq_equal", encode_i(`MIPS_OP_BEQ, 7, 7, 16'hfffd), 1);
        run_instr("beq_unequal", encode_i(`MIPS_OP_BEQ, 7, 8, 16'h0010), 1);
        run_instr("bne_unequal", encode_i(`MIPS_OP_BNE, 7, 8, 16'h8001), 1);
        run_instr("bne_equal", encode_i(`MIPS_OP_BNE, 9, 9, 16'h0004), 1);
        run_instr("j", {`MIPS_OP_J, 26'h2a5_5a5c}, 1);
        run_instr("jr", encode_r(`MIPS_FC_JR, 6, 0, 0, 0), 1);
        run_instr("jal", {`MIPS_OP_JAL, 26'h13f_0c01}, 1);
        run_instr("step_hold", encode_r(`MIPS_FC_SUBU, 10, 11, 12, 0), 5);

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before the tests finished.");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/instruction_decode.sv
verilog/id_ex.sv
verilog/execute.sv
verilog/decode_execute_top.sv
dv/tb_decode_execute.sv

/* verilog/control_unit.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module control_unit (
    input  mips_pkg::opcode_t  i_op_code,
    input  mips_pkg::funct_t   i_funct_code,
    output mips_pkg::id_ctrl_t o_ctrl
);

    always_comb begin
        o_ctrl = '0;  // unknown opcodes do nothing.
        case (i_op_code)
            `MIPS_OP_RTYPE: begin
                case (i_funct_code)
                    `MIPS_FC_ADDU, `MIPS_FC_SUBU, `MIPS_FC_AND, `MIPS_FC_OR,
                    `MIPS_FC_XOR, `MIPS_FC_NOR, `MIPS_FC_SLT, `MIPS_FC_SLL,
                    `MIPS_FC_SRL, `MIPS_FC_SRA: begin
                        o_ctrl.reg_dst_sel = 1'b1;
                        o_ctrl.reg_write   = 1'b1;
                    end
                    `MIPS_FC_JR: begin
                        o_ctrl.jump     = 1'b1;
                        o_ctrl.jump_reg = 1'b1;
                    end
                    default: o_ctrl = '0;
                endcase
            end
            `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_ANDI,
            `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU, `MIPS_OP_LHU: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_read  = 1'b1;
                o_ctrl.reg_write = 1'b1;
                case (i_op_code)
                    `MIPS_OP_LB:  o_ctrl.word_size = `MIPS_SIZE_BYTE;
                    `MIPS_OP_LH:  o_ctrl.word_size = `MIPS_SIZE_HALF;
                    `MIPS_OP_LBU: o_ctrl.word_size = `MIPS_SIZE_BYTE | `MIPS_SIZE_UNSIGNED;
                    `MIPS_OP_LHU: o_ctrl.word_size = `MIPS_SIZE_HALF | `MIPS_SIZE_UNSIGNED;
                    default:      o_ctrl.word_size = `MIPS_SIZE_WORD;
                endcase
            end
            `MIPS_OP_SB, `MIPS_OP_SH, `MIPS_OP_SW: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                case (i_op_code)
                    `MIPS_OP_SB: o_ctrl.word_size = `MIPS_SIZE_BYTE;
                    `MIPS_OP_SH: o_ctrl.word_size = `MIPS_SIZE_HALF;
                    default:     o_ctrl.word_size = `MIPS_SIZE_WORD;
                endcase
            end
            `MIPS_OP_BEQ: o_ctrl.branch = 1'b1;
            `MIPS_OP_BNE: begin
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = 1'b1;
            end
            `MIPS_OP_J:   o_ctrl.jump = 1'b1;
            `MIPS_OP_JAL: begin
                o_ctrl.jump      = 1'b1;
                o_ctrl.link      = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            default: o_ctrl = '0;
        endcase
    end

    always_comb begin
        assert final (!(o_ctrl.mem_read && o_ctrl.mem_write))
            else $error("control_unit: load and store decoded together.");
    end

endmodule

/* verilog/decode_execute_top.sv */
`timescale 1ns/10ps

module decode_execute_top (
    input                        i_clk,
    input                        i_reset,
    input                        i_step,
    input  mips_pkg::word_t      i_instruction,
    input  mips_pkg::word_t      i_pc4,
    input                        i_wb_write,
    input  mips_pkg::reg_addr_t  i_wb_addr,
    input  mips_pkg::word_t      i_wb_data,
    output mips_pkg::word_t      o_alu_result,
    output mips_pkg::word_t      o_store_data,
    output mips_pkg::reg_addr_t  o_write_reg,
    output logic                 o_reg_write,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output mips_pkg::word_size_t o_word_size,
    output logic                 o_branch_taken,
    output mips_pkg::word_t      o_branch_target,
    output logic                 o_jump,
    output mips_pkg::word_t      o_jump_target
);

    mips_pkg::id_ex_t id_payload;  // decode side.
    mips_pkg::id_ex_t ex_payload;  // registered.

    instruction_decode u_instruction_decode (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instruction (i_instruction),
        .i_pc4         (i_pc4),
        .i_wb_write    (i_wb_write),
        .i_wb_addr     (i_wb_addr),
        .i_wb_data     (i_wb_data),
        .o_id_ex       (id_payload)
    );

    id_ex u_id_ex (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_step  (i_step),
        .i_id_ex (id_payload),
        .o_id_ex (ex_payload)
    );

    execute u_execute (
        .i_id_ex         (ex_payload),
        .o_alu_result    (o_alu_result),
        .o_store_data    (o_store_data),
        .o_write_reg     (o_write_reg),
        .o_reg_write     (o_reg_write),
        .o_mem_read      (o_mem_read),
        .o_mem_write     (o_mem_write),
        .o_word_size     (o_word_size),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_jump          (o_jump),
        .o_jump_target   (o_jump_target)
    );

endmodule

/* verilog/execute.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module execute (
    input  mips_pkg::id_ex_t     i_id_ex,
    output mips_pkg::word_t      o_alu_result,
    output mips_pkg::word_t      o_store_data,
    output mips_pkg::reg_addr_t  o_write_reg,
    output logic                 o_reg_write,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output mips_pkg::word_size_t o_word_size,
    output logic                 o_branch_taken,
    output mips_pkg::word_t      o_branch_target,
    output logic                 o_jump,
    output mips_pkg::word_t      o_jump_target
);

    mips_pkg::word_t data_a;
    mips_pkg::word_t data_b;
    mips_pkg::word_t ext;
    mips_pkg::word_t operand_b;
    logic            less;

    assign data_a    = i_id_ex.data_a;
    assign data_b    = i_id_ex.data_b;
    assign ext       = i_id_ex.extension_result;
    assign operand_b = i_id_ex.ctrl.alu_src ? ext : data_b;
    assign less      = $signed(data_a) < $signed(operand_b);

    // ---------------------------------------------------------------------------
    // alu.
    always_comb begin
        case (i_id_ex.op_code)
            `MIPS_OP_RTYPE: begin
                case (i_id_ex.funct_code)
                    `MIPS_FC_ADDU: o_alu_result = data_a + operand_b;
                    `MIPS_FC_SUBU: o_alu_result = data_a - operand_b;
                    `MIPS_FC_AND:  o_alu_result = data_a & operand_b;
                    `MIPS_FC_OR:   o_alu_result = data_a | operand_b;
                    `MIPS_FC_XOR:  o_alu_result = data_a ^ operand_b;
                    `MIPS_FC_NOR:  o_alu_result = ~(data_a | operand_b);
                    `MIPS_FC_SLT:  o_alu_result = mips_pkg::word_t'(less);
                    `MIPS_FC_SLL:  o_alu_result = data_b << i_id_ex.shamt;
                    `MIPS_FC_SRL:  o_alu_result = data_b >> i_id_ex.shamt;
                    `MIPS_FC_SRA:  o_alu_result = $signed(data_b) >>> i_id_ex.shamt;
                    default:       o_alu_result = '0;  // jr included.
                endcase
            end
            `MIPS_OP_ADDIU, `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW, `MIPS_OP_LBU,
            `MIPS_OP_LHU, `MIPS_OP_SB, `MIPS_OP_SH, `MIPS_OP_SW:
                o_alu_result = data_a + operand_b;  // address too.
            `MIPS_OP_SLTI: o_alu_result = mips_pkg::word_t'(less);
            `MIPS_OP_ANDI: o_alu_result = data_a & operand_b;
            `MIPS_OP_ORI:  o_alu_result = data_a | operand_b;
            `MIPS_OP_XORI: o_alu_result = data_a ^ operand_b;
            `MIPS_OP_LUI:  o_alu_result = {ext[15:0], 16'b0};
            `MIPS_OP_JAL:  o_alu_result = i_id_ex.pc4;  // link value.
            default:       o_alu_result = '0;
        endcase
    end

    // ---------------------------------------------------------------------------
    // branch and jump.
    assign o_branch_taken  = i_id_ex.ctrl.branch &&
                             (i_id_ex.ctrl.branch_ne ? (data_a != data_b)
                                                     : (data_a == data_b));
    assign o_branch_target = i_id_ex.pc4 + {ext[29:0], 2'b00};
    assign o_jump          = i_id_ex.ctrl.jump;
    assign o_jump_target   = i_id_ex.ctrl.jump_reg ? data_a
                             : {i_id_ex.pc4[31:28], i_id_ex.jump_index, 2'b00};

    assign o_store_data = data_b;
    assign o_write_reg  = i_id_ex.write_reg;
    assign o_reg_write  = i_id_ex.ctrl.reg_write;
    assign o_mem_read   = i_id_ex.ctrl.mem_read;
    assign o_mem_write  = i_id_ex.ctrl.mem_write;
    assign o_word_size  = i_id_ex.ctrl.word_size;

endmodule

/* verilog/id_ex.sv */
`timescale 1ns/10ps

module id_ex (
    input                     i_clk,
    input                     i_reset,
    input                     i_step,
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::id_ex_t  o_id_ex
);

    // holds while i_step is low.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex <= '0;
        end else if (i_step) begin
            o_id_ex <= i_id_ex;
        end
    end

    // ---------------------------------------------------------------------------
    // a reset bubble must not touch memory or the register file.
    a_reset_bubble: assert property (
        @(posedge i_clk)
        i_reset |=> !(o_id_ex.ctrl.mem_read || o_id_ex.ctrl.mem_write ||
                      o_id_ex.ctrl.reg_write)
    ) else $error("id_ex: write control active after reset.");

endmodule

/* verilog/instruction_decode.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module instruction_decode (
    input                        i_clk,
    input                        i_reset,
    input  mips_pkg::word_t      i_instruction,
    input  mips_pkg::word_t      i_pc4,
    input                        i_wb_write,
    input  mips_pkg::reg_addr_t  i_wb_addr,
    input  mips_pkg::word_t      i_wb_data,
    output mips_pkg::id_ex_t     o_id_ex
);

    mips_pkg::opcode_t   op_code;
    mips_pkg::funct_t    funct_code;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [`MIPS_NB_IMM-1:0] imm;
    logic                zero_ext;
    mips_pkg::id_ctrl_t  ctrl;
    mips_pkg::word_t     data_a;
    mips_pkg::word_t     data_b;

    // ---------------------------------------------------------------------------
    // field split.
    assign op_code    = i_instruction[31:26];
    assign rs         = i_instruction[25:21];
    assign rt         = i_instruction[20:16];
    assign rd         = i_instruction[15:11];
    assign imm        = i_instruction[15:0];
    assign funct_code = i_instruction[5:0];

    control_unit u_control_unit (
        .i_op_code    (op_code),
        .i_funct_code (funct_code),
        .o_ctrl       (ctrl)
    );

    register_file u_register_file (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_read_addr_a (rs),
        .i_read_addr_b (rt),
        .i_write       (i_wb_write),
        .i_write_addr  (i_wb_addr),
        .i_write_data  (i_wb_data),
        .o_read_data_a (data_a),
        .o_read_data_b (data_b)
    );

    // logical immediates are zero extended.
    assign zero_ext = (op_code == `MIPS_OP_ANDI) || (op_code == `MIPS_OP_ORI) ||
                      (op_code == `MIPS_OP_XORI);

    always_comb begin
        o_id_ex                  = '0;
        o_id_ex.ctrl             = ctrl;
        o_id_ex.op_code          = op_code;
        o_id_ex.funct_code       = funct_code;
        o_id_ex.shamt            = i_instruction[10:6];
        o_id_ex.data_a           = data_a;
        o_id_ex.data_b           = data_b;
        o_id_ex.extension_result = zero_ext ? {{(`MIPS_NB - `MIPS_NB_IMM){1'b0}}, imm}
                                            : {{(`MIPS_NB - `MIPS_NB_IMM){imm[15]}}, imm};
        o_id_ex.pc4              = i_pc4;
        o_id_ex.jump_index       = i_instruction[25:0];
        if (ctrl.link)
            o_id_ex.write_reg = `MIPS_REG_LINK;
        else if (ctrl.reg_dst_sel)
            o_id_ex.write_reg = rd;  // r-type.
        else
            o_id_ex.write_reg = rt;
    end

endmodule

/* verilog/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_NB             32
`define MIPS_NB_OPCODE      6
`define MIPS_NB_FCODE       6
`define MIPS_NB_SIZE_TYPE   3
`define MIPS_NB_REG_ADDR    5
`define MIPS_NB_SHAMT       5
`define MIPS_NB_IMM         16
`define MIPS_NB_JUMP_INDEX  26

`define MIPS_REG_LINK       5'd31  // jal destination.

// ---------------------------------------------------------------------------
// opcodes.
`define MIPS_OP_RTYPE  6'b000000
`define MIPS_OP_J      6'b000010
`define MIPS_OP_JAL    6'b000011
`define MIPS_OP_BEQ    6'b000100
`define MIPS_OP_BNE    6'b000101
`define MIPS_OP_ADDIU  6'b001001
`define MIPS_OP_SLTI   6'b001010
`define MIPS_OP_ANDI   6'b001100
`define MIPS_OP_ORI    6'b001101
`define MIPS_OP_XORI   6'b001110
`define MIPS_OP_LUI    6'b001111
`define MIPS_OP_LB     6'b100000
`define MIPS_OP_LH     6'b100001
`define MIPS_OP_LW     6'b100011
`define MIPS_OP_LBU    6'b100100
`define MIPS_OP_LHU    6'b100101
`define MIPS_OP_SB     6'b101000
`define MIPS_OP_SH     6'b101001
`define MIPS_OP_SW     6'b101011

// ---------------------------------------------------------------------------
// r-type function codes.
`define MIPS_FC_SLL    6'b000000
`define MIPS_FC_SRL    6'b000010
`define MIPS_FC_SRA    6'b000011
`define MIPS_FC_JR     6'b001000
`define MIPS_FC_ADDU   6'b100001
`define MIPS_FC_SUBU   6'b100011
`define MIPS_FC_AND    6'b100100
`define MIPS_FC_OR     6'b100101
`define MIPS_FC_XOR    6'b100110
`define MIPS_FC_NOR    6'b100111
`define MIPS_FC_SLT    6'b101010

// bit 2 of the access size marks an unsigned load.
`define MIPS_SIZE_BYTE      3'b001
`define MIPS_SIZE_HALF      3'b010
`define MIPS_SIZE_WORD      3'b011
`define MIPS_SIZE_UNSIGNED  3'b100

`endif

/* verilog/mips_pkg.sv */
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`MIPS_NB-1:0]            word_t;
    typedef logic [`MIPS_NB_OPCODE-1:0]     opcode_t;
    typedef logic [`MIPS_NB_FCODE-1:0]      funct_t;
    typedef logic [`MIPS_NB_REG_ADDR-1:0]   reg_addr_t;
    typedef logic [`MIPS_NB_SIZE_TYPE-1:0]  word_size_t;
    typedef logic [`MIPS_NB_SHAMT-1:0]      shamt_t;
    typedef logic [`MIPS_NB_JUMP_INDEX-1:0] jump_index_t;

    // decoded control.
    typedef struct packed {
        logic       alu_src;      // 0 data_b, 1 immediate.
        logic       reg_dst_sel;  // 1 selects rd.
        logic       branch;
        logic       branch_ne;
        logic       jump;
        logic       jump_reg;
        logic       link;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        word_size_t word_size;
    } id_ctrl_t;

    // id/ex payload.
    typedef struct packed {
        id_ctrl_t    ctrl;
        opcode_t     op_code;
        funct_t      funct_code;
        shamt_t      shamt;
        word_t       data_a;
        word_t       data_b;
        word_t       extension_result;
        word_t       pc4;
        jump_index_t jump_index;
        reg_addr_t   write_reg;
    } id_ex_t;

endpackage

/* verilog/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input                        i_clk,
    input                        i_reset,
    input  mips_pkg::reg_addr_t  i_read_addr_a,
    input  mips_pkg::reg_addr_t  i_read_addr_b,
    input                        i_write,
    input  mips_pkg::reg_addr_t  i_write_addr,
    input  mips_pkg::word_t      i_write_data,
    output mips_pkg::word_t      o_read_data_a,
    output mips_pkg::word_t      o_read_data_b
);

    localparam int N_REGS = 2 ** $bits(mips_pkg::reg_addr_t);

    mips_pkg::word_t regs [N_REGS];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && (i_write_addr != '0)) begin  // r0 stays zero.
            regs[i_write_addr] <= i_write_data;
        end
    end

    // no write-through.
    assign o_read_data_a = regs[i_read_addr_a];
    assign o_read_data_b = regs[i_read_addr_b];

    // ---------------------------------------------------------------------------
    // r0 must never pick up a write-back.
    a_r0_reads_zero: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_read_addr_a == '0) |-> (o_read_data_a == '0)
    ) else $error("register_file: r0 read nonzero on port a.");

    b_r0_reads_zero: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_read_addr_b == '0) |-> (o_read_data_b == '0)
    ) else $error("register_file: r0 read nonzero on port b.");

endmodule
